// File: design/trace_cfg_pkg.sv
// Trace unit sizing
// Widths and counts shared by every block of the instruction trace unit
`default_nettype none

package trace_cfg_pkg;

    // Pipeline depth of the watched processor
    localparam int NUM_STAGES = 5;

    // Instruction id and cycle stamp widths
    localparam int ID_W    = 8;
    localparam int STAMP_W = 16;

    // Record store, one slot per live id, needs at least NUM_STAGES slots
    localparam int SLOT_BITS = 3;
    localparam int SLOTS     = 1 << SLOT_BITS;

    // Payload and statistics widths
    localparam int INSTR_W = 32;
    localparam int FLUSH_W = 16;

endpackage

`default_nettype wire

// File: design/trace_rec_pkg.sv
// Trace record types
// Stage numbering, controller states and the per-record stamp vector
`default_nettype none

package trace_rec_pkg;

    import trace_cfg_pkg::*;

    //////////////////////////////
    // Pipeline stage indices
    //////////////////////////////
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } stage_e;

    // Trace session controller
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_e;

    // One entry cycle per stage, indexed by stage_e
    typedef logic [NUM_STAGES-1:0][STAMP_W-1:0] stamp_vec_t;

endpackage

`default_nettype wire

// File: design/stage_tag_if.sv
// Stage tag bus
// Carries the per-stage valid and id state from the tag pipeline,
// together with the entry, accept and kill events, to the counters
// and the stamp store
`timescale 1ns/1ps
`default_nettype none

interface stage_tag_if
    import trace_cfg_pkg::*;
();

    logic [NUM_STAGES-1:0]           stage_valid;
    logic [NUM_STAGES-1:0][ID_W-1:0] stage_id;
    // High in the first cycle a stage holds a new tag
    logic [NUM_STAGES-1:0]           stage_enter;
    logic                            accept;
    logic [1:0]                      kill_count;
    logic [ID_W-1:0]                 next_id;

    modport pipe (output stage_valid, stage_id, stage_enter, accept, kill_count,
                  input next_id);

    modport count (input accept, kill_count,
                   output next_id);

    modport store (input stage_valid, stage_id, stage_enter, accept);

endinterface

`default_nettype wire

// File: design/trace_ctrl.sv
// Trace session controller
// Opens a trace session on trace_enable, gates new tags while running,
// and drains the tag pipeline before going idle again
`timescale 1ns/1ps
`default_nettype none

module trace_ctrl
    import trace_rec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic trace_enable,
    input  logic pipe_empty,
    output logic capture_en,
    output logic start,
    output logic busy
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    //////////////////////////////
    // Next state
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (trace_enable) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (!trace_enable) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // Wait for in-flight tags to leave writeback
                if (pipe_empty) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Start is seen at the edge that enters RUN, so the cycle count is zero there
    assign start      = (state_q == IDLE) && trace_enable;
    assign capture_en = (state_q == RUN);
    assign busy       = (state_q != IDLE);

endmodule

`default_nettype wire

// File: design/trace_counter.sv
// Trace counters
// Free-running cycle counter restarted per session, instruction id
// allocator and saturating count of flushed instructions
`timescale 1ns/1ps
`default_nettype none

module trace_counter
    import trace_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    stage_tag_if.count         tags,
    output logic [STAMP_W-1:0] cycle_now,
    output logic [FLUSH_W-1:0] flush_count
);

    logic [ID_W-1:0]  alloc_q;
    logic [FLUSH_W:0] flush_sum;

    // Cycle counter, zero in the first cycle of a session
    always_ff @(posedge clk) begin
        if (rst || start) begin
            cycle_now <= '0;
        end else begin
            cycle_now <= cycle_now + 1'b1;
        end
    end

    //////////////////////////////
    // Id allocation
    //////////////////////////////
    // The id taken at an edge is already counted while accept is high,
    // so back-to-back fetches see consecutive ids
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_q <= '0;
        end else if (tags.accept) begin
            alloc_q <= alloc_q + 1'b1;
        end
    end

    assign tags.next_id = alloc_q + ID_W'(tags.accept);

    // Flush statistics, held at the top value once full
    assign flush_sum = {1'b0, flush_count} + (FLUSH_W + 1)'(tags.kill_count);

    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (flush_sum[FLUSH_W]) begin
            flush_count <= '1;
        end else begin
            flush_count <= flush_sum[FLUSH_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: design/tag_pipe.sv
// Tag pipeline
// Shadows the processor pipeline with one valid bit and one instruction
// id per stage, following its stall and flush. Also reports stage entry,
// new fetches and the number of tags killed by a flush
`timescale 1ns/1ps
`default_nettype none

module tag_pipe
    import trace_cfg_pkg::*;
    import trace_rec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       capture_en,
    input  logic       fetch_valid,
    input  logic       stall,
    input  logic       flush,
    stage_tag_if.pipe  tags,
    output logic       pipe_empty
);

    logic [NUM_STAGES-1:0]           valid_q;
    logic [NUM_STAGES-1:0]           valid_d;
    logic [NUM_STAGES-1:0][ID_W-1:0] id_q;
    logic [NUM_STAGES-1:0][ID_W-1:0] id_d;
    logic [NUM_STAGES-1:0]           enter_q;
    logic [NUM_STAGES-1:0]           enter_d;
    logic                            take;
    logic                            accept_q;
    logic [1:0]                      kill_q;
    logic [1:0]                      kill_d;

    //////////////////////////////
    // Stage update
    //////////////////////////////
    always_comb begin
        take    = fetch_valid && capture_en && !stall && !flush;
        valid_d = valid_q;
        id_d    = id_q;
        if (!stall) begin
            for (int s = NUM_STAGES - 1; s > 0; s--) begin
                valid_d[s] = valid_q[s-1];
                id_d[s]    = id_q[s-1];
            end
            valid_d[FETCH] = take;
            id_d[FETCH]    = tags.next_id;
        end
        if (flush) begin
            valid_d[FETCH]  = 1'b0;
            valid_d[DECODE] = 1'b0;
            // The killed decode tag must not move on into execute
            if (!stall) begin
                valid_d[EXECUTE] = 1'b0;
            end
        end
        enter_d = stall ? '0 : valid_d;
        kill_d  = flush ? ({1'b0, valid_q[FETCH]} + {1'b0, valid_q[DECODE]}) : 2'd0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= '0;
            enter_q  <= '0;
            accept_q <= 1'b0;
            kill_q   <= 2'd0;
        end else begin
            valid_q  <= valid_d;
            enter_q  <= enter_d;
            accept_q <= take;
            kill_q   <= kill_d;
        end
    end

    always_ff @(posedge clk) begin
        id_q <= id_d;
    end

    assign tags.stage_valid = valid_q;
    assign tags.stage_id    = id_q;
    assign tags.stage_enter = enter_q;
    assign tags.accept      = accept_q;
    assign tags.kill_count  = kill_q;
    assign pipe_empty       = ~|valid_q;

endmodule

`default_nettype wire

// File: design/stamp_store.sv
// Stamp store and record output
// Keeps the instruction word and the stage entry cycles of each live id,
// and presents one record strobe when a tag leaves writeback
`timescale 1ns/1ps
`default_nettype none

module stamp_store
    import trace_cfg_pkg::*;
    import trace_rec_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [INSTR_W-1:0] fetch_instr,
    input  logic [STAMP_W-1:0] cycle_now,
    stage_tag_if.store         tags,
    output logic               rec_valid,
    output logic [ID_W-1:0]    rec_id,
    output logic [INSTR_W-1:0] rec_instr,
    output stamp_vec_t         rec_stamps
);

    logic [INSTR_W-1:0]   instr_q;
    logic [INSTR_W-1:0]   instr_mem [SLOTS];
    stamp_vec_t           stamp_mem [SLOTS];
    logic [SLOT_BITS-1:0] wb_slot;
    stamp_vec_t           rd_stamps;
    logic                 wb_live_q;

    //////////////////////////////
    // Slot writes
    //////////////////////////////
    // instr_q holds the word sampled at the edge where the tag entered fetch
    always_ff @(posedge clk) begin
        instr_q <= fetch_instr;
        if (tags.accept) begin
            instr_mem[tags.stage_id[FETCH][SLOT_BITS-1:0]] <= instr_q;
        end
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (tags.stage_enter[s]) begin
                stamp_mem[tags.stage_id[s][SLOT_BITS-1:0]][s] <= cycle_now;
            end
        end
    end

    //////////////////////////////
    // Record capture
    //////////////////////////////
    assign wb_slot = tags.stage_id[WRITEBACK][SLOT_BITS-1:0];

    // Writeback stamp lands in the slot at the same edge, so take it directly
    always_comb begin
        rd_stamps = stamp_mem[wb_slot];
        if (tags.stage_enter[WRITEBACK]) begin
            rd_stamps[WRITEBACK] = cycle_now;
        end
    end

    // Follow the writeback tag every cycle it is there
    always_ff @(posedge clk) begin
        if (tags.stage_valid[WRITEBACK]) begin
            rec_id     <= tags.stage_id[WRITEBACK];
            rec_instr  <= instr_mem[wb_slot];
            rec_stamps <= rd_stamps;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_live_q <= 1'b0;
        end else begin
            wb_live_q <= tags.stage_valid[WRITEBACK];
        end
    end

    // The tag has left when writeback is now empty or holds a fresh tag
    assign rec_valid = wb_live_q &&
                       (!tags.stage_valid[WRITEBACK] || tags.stage_enter[WRITEBACK]);

endmodule

`default_nettype wire

// File: design/pipe_trace_top.sv
// Pipeline instruction trace unit
// Watches a five-stage processor through its fetch, stall and flush
// signals and emits one timestamped record per retired instruction
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_top
    import trace_cfg_pkg::*;
    import trace_rec_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               trace_enable,
    input  logic               fetch_valid,
    input  logic [INSTR_W-1:0] fetch_instr,
    input  logic               stall,
    input  logic               flush,
    output logic               rec_valid,
    output logic [ID_W-1:0]    rec_id,
    output logic [INSTR_W-1:0] rec_instr,
    output stamp_vec_t         rec_stamps,
    output logic [FLUSH_W-1:0] flush_count,
    output logic               busy
);

    logic               capture_en;
    logic               start;
    logic               pipe_empty;
    logic [STAMP_W-1:0] cycle_now;

    stage_tag_if tags ();

    trace_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .trace_enable (trace_enable),
        .pipe_empty   (pipe_empty),
        .capture_en   (capture_en),
        .start        (start),
        .busy         (busy)
    );

    trace_counter u_counter (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .tags        (tags.count),
        .cycle_now   (cycle_now),
        .flush_count (flush_count)
    );

    tag_pipe u_pipe (
        .clk         (clk),
        .rst         (rst),
        .capture_en  (capture_en),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .tags        (tags.pipe),
        .pipe_empty  (pipe_empty)
    );

    stamp_store u_store (
        .clk         (clk),
        .rst         (rst),
        .fetch_instr (fetch_instr),
        .cycle_now   (cycle_now),
        .tags        (tags.store),
        .rec_valid   (rec_valid),
        .rec_id      (rec_id),
        .rec_instr   (rec_instr),
        .rec_stamps  (rec_stamps)
    );

endmodule

`default_nettype wire

// File: bench/pipe_trace_tb.sv
// Trace unit testbench
// Drives fetch, stall, flush and trace_enable, runs a reference model of
// the tag pipeline and checks records, flush count and busy by assertions
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_tb
    import trace_cfg_pkg::*;
    import trace_rec_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    // Roughly three times the full test sequence
    localparam int WATCHDOG_CYCLES = 2000;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [INSTR_W-1:0] instr;
        stamp_vec_t         stamps;
    } trace_rec_t;

    logic clk;
    logic rst;
    logic trace_enable;
    logic fetch_valid;
    logic [INSTR_W-1:0] fetch_instr;
    logic stall;
    logic flush;
    logic rec_valid;
    logic [ID_W-1:0] rec_id;
    logic [INSTR_W-1:0] rec_instr;
    stamp_vec_t rec_stamps;
    logic [FLUSH_W-1:0] flush_count;
    logic busy;

    // Reference model state
    ctrl_state_e m_state;
    logic [STAMP_W-1:0] m_cycle;
    logic [STAMP_W-1:0] cycle_next;
    logic [NUM_STAGES-1:0] m_valid;
    logic [ID_W-1:0] m_id [NUM_STAGES];
    logic [INSTR_W-1:0] m_instr [NUM_STAGES];
    stamp_vec_t m_stamps [NUM_STAGES];
    logic [ID_W-1:0] m_next_id;
    logic [FLUSH_W-1:0] m_flush;
    int kill_pend;
    int kills;
    int flush_sum;
    logic start_now;
    logic take;
    logic empty_now;
    trace_rec_t exp_q [$];
    logic head_valid;
    trace_rec_t head;

    int errors;
    int rec_seen;
    int rec_expected;

    pipe_trace_top dut (
        .clk          (clk),
        .rst          (rst),
        .trace_enable (trace_enable),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .stall        (stall),
        .flush        (flush),
        .rec_valid    (rec_valid),
        .rec_id       (rec_id),
        .rec_instr    (rec_instr),
        .rec_stamps   (rec_stamps),
        .flush_count  (flush_count),
        .busy         (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            m_state = IDLE;
            m_cycle = '0;
            m_valid = '0;
            m_next_id = '0;
            m_flush = '0;
            kill_pend = 0;
            exp_q.delete();
            head_valid = 1'b0;
        end else begin
            start_now = (m_state == IDLE) && trace_enable;
            cycle_next = start_now ? '0 : m_cycle + 1'b1;
            take = fetch_valid && (m_state == RUN) && !stall && !flush;
            kills = flush ? (int'(m_valid[FETCH]) + int'(m_valid[DECODE])) : 0;
            empty_now = (m_valid == '0);
            // The record shown during the last cycle has been checked
            if (head_valid) begin
                void'(exp_q.pop_front());
            end
            if (m_valid[WRITEBACK] && !stall) begin
                exp_q.push_back(trace_rec_t'{m_id[WRITEBACK], m_instr[WRITEBACK],
                                             m_stamps[WRITEBACK]});
                rec_expected++;
            end
            if (!stall) begin
                for (int s = NUM_STAGES - 1; s > 0; s--) begin
                    m_valid[s] = m_valid[s-1];
                    m_id[s] = m_id[s-1];
                    m_instr[s] = m_instr[s-1];
                    m_stamps[s] = m_stamps[s-1];
                    m_stamps[s][s] = cycle_next;
                end
                m_valid[FETCH] = take;
                m_id[FETCH] = m_next_id;
                m_instr[FETCH] = fetch_instr;
                m_stamps[FETCH] = '0;
                m_stamps[FETCH][FETCH] = cycle_next;
            end
            if (flush) begin
                m_valid[FETCH] = 1'b0;
                m_valid[DECODE] = 1'b0;
                if (!stall) begin
                    m_valid[EXECUTE] = 1'b0;
                end
            end
            if (take) begin
                m_next_id = m_next_id + 1'b1;
            end
            // Kills reach the flush counter one cycle after the flush edge
            flush_sum = int'(m_flush) + kill_pend;
            m_flush = (flush_sum > (2 ** FLUSH_W - 1)) ? '1 : FLUSH_W'(flush_sum);
            kill_pend = kills;
            case (m_state)
                IDLE:    m_state = trace_enable ? RUN : IDLE;
                RUN:     m_state = trace_enable ? RUN : DRAIN;
                default: m_state = empty_now ? IDLE : DRAIN;
            endcase
            m_cycle = cycle_next;
            head_valid = (exp_q.size() > 0);
            if (head_valid) begin
                head = exp_q[0];
            end
        end
    end

    //////////////////////////////
    // Assertions
    //////////////////////////////
    a_rec_valid: assert property (@(posedge clk) disable iff (rst) rec_valid == head_valid)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t rec_valid got %0b exp %0b",
                     $time, $sampled(rec_valid), $sampled(head_valid));
        end

    a_rec_id: assert property (@(posedge clk) disable iff (rst)
                               !(rec_valid && head_valid) || rec_id == head.id)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t rec_id got %0h exp %0h",
                     $time, $sampled(rec_id), $sampled(head.id));
        end

    a_rec_instr: assert property (@(posedge clk) disable iff (rst)
                                  !(rec_valid && head_valid) || rec_instr == head.instr)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t rec_instr got %h exp %h",
                     $time, $sampled(rec_instr), $sampled(head.instr));
        end

    a_rec_stamps: assert property (@(posedge clk) disable iff (rst)
                                   !(rec_valid && head_valid) || rec_stamps == head.stamps)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t rec_stamps got %h exp %h",
                     $time, $sampled(rec_stamps), $sampled(head.stamps));
        end

    a_flush_count: assert property (@(posedge clk) disable iff (rst) flush_count == m_flush)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t flush_count got %0d exp %0d",
                     $time, $sampled(flush_count), $sampled(m_flush));
        end

    a_busy: assert property (@(posedge clk) disable iff (rst) busy == (m_state != IDLE))
        else begin
            errors++;
            $display("CHECK FAILED t=%0t busy got %0b exp %0b",
                     $time, $sampled(busy), $sampled(m_state != IDLE));
        end

    // Records seen on the DUT output
    always @(negedge clk) begin
        if (!rst && rec_valid) begin
            rec_seen++;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic drive(input logic fv, input logic st, input logic fl);
        @(negedge clk);
        fetch_valid = fv;
        stall = st;
        flush = fl;
        fetch_instr = $urandom();
    endtask

    task automatic begin_session();
        @(negedge clk);
        trace_enable = 1'b1;
        fetch_valid = 1'b0;
        drive(1'b0, 1'b0, 1'b0);
    endtask

    // Drop trace_enable and wait for busy to fall
    task automatic end_session(input logic fv);
        int n;
        @(negedge clk);
        trace_enable = 1'b0;
        fetch_valid = fv;
        stall = 1'b0;
        flush = 1'b0;
        n = 0;
        while (busy && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            errors++;
            $display("busy stayed high 100 cycles after trace_enable was lowered");
        end
        fetch_valid = 1'b0;
        @(negedge clk);
        assert (rec_seen == rec_expected && exp_q.size() == 0) else begin
            errors++;
            $display("CHECK FAILED t=%0t record count got %0d exp %0d",
                     $time, rec_seen, rec_expected);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("test %0d %s: %s", num, name, (errors == errors_before) ? "ok" : "errors");
    endtask

    initial begin
        int mark;
        int fetches;
        logic fv;
        clk = 1'b0;
        rst = 1'b1;
        trace_enable = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        errors = 0;
        rec_seen = 0;
        rec_expected = 0;
        void'($urandom(52));
        repeat (10) @(negedge clk);
        rst = 1'b0;

        mark = errors;
        repeat (4) drive(1'b0, 1'b0, 1'b0);
        report_test(1, "reset state", mark);

        mark = errors;
        begin_session();
        repeat (12) drive(1'b1, 1'b0, 1'b0);
        end_session(1'b0);
        report_test(2, "back-to-back fetch", mark);

        mark = errors;
        begin_session();
        for (int i = 0; i < 24; i++) begin
            drive(1'b1, 1'b0, 1'b0);
            if ($urandom() % 3 == 0) begin
                repeat (1 + $urandom() % 4) drive(1'b1, 1'b1, 1'b0);
            end
        end
        end_session(1'b0);
        report_test(3, "stall bursts", mark);

        mark = errors;
        begin_session();
        repeat (6) drive(1'b1, 1'b0, 1'b0);
        drive(1'b1, 1'b0, 1'b1);
        repeat (4) drive(1'b1, 1'b0, 1'b0);
        drive(1'b1, 1'b1, 1'b1);
        repeat (5) drive(1'b1, 1'b0, 1'b0);
        drive(1'b0, 1'b0, 1'b1);
        repeat (3) drive(1'b1, 1'b0, 1'b0);
        end_session(1'b0);
        report_test(4, "flush", mark);

        // Fetches keep coming while draining and must be ignored
        mark = errors;
        begin_session();
        repeat (6) drive(1'b1, 1'b0, 1'b0);
        end_session(1'b1);
        begin_session();
        repeat (6) drive(1'b1, 1'b0, 1'b0);
        end_session(1'b0);
        report_test(5, "disable and restart", mark);

        mark = errors;
        fetches = 0;
        begin_session();
        while (fetches < 300) begin
            fv = ($urandom() % 4 != 0);
            drive(fv, $urandom() % 6 == 0, $urandom() % 20 == 0);
            if (fv) begin
                fetches++;
            end
        end
        end_session(1'b0);
        report_test(6, "random stream", mark);

        $display("tests 6, records %0d, errors %0d", rec_seen, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d clock periods",
                 WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
design/trace_cfg_pkg.sv
design/trace_rec_pkg.sv
design/stage_tag_if.sv
design/trace_ctrl.sv
design/trace_counter.sv
design/tag_pipe.sv
design/stamp_store.sv
design/pipe_trace_top.sv
bench/pipe_trace_tb.sv
